// File: Bender.yml
package:
  name: rv_core

sources:
  - verilog/rv_pkg.sv
  - verilog/rv_decoder.sv
  - verilog/rv_regfile.sv
  - verilog/rv_execute.sv
  - verilog/rv_lsu.sv
  - verilog/rv_core.sv
  - target: test
    files:
      - dv/rv_core_props.sv
      - dv/rv_core_tb.sv

// File: dv/rv_core_props.sv
// Wishbone request and halt properties of the RV32I core
`timescale 1ns/1ps
`default_nettype none

module rv_core_props (
    input logic            clk,
    input logic            reset,
    input rv_pkg::wb_req_t wb_req,
    input rv_pkg::wb_rsp_t wb_rsp,
    input logic            halted
);
    import rv_pkg::*;

    int unsigned fail_count = 0; // Failed assertions so far

    a_stb_cyc: assert property (@(posedge clk) disable iff (reset) wb_req.stb |-> wb_req.cyc)
        else begin
            $error("stb without cyc");
            fail_count++;
        end

    // Request held until ack
    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        wb_req.stb && !wb_rsp.ack |=> wb_req.stb && $stable(wb_req.adr) &&
                                      $stable(wb_req.we) && $stable(wb_req.sel))
        else begin
            $error("request changed before ack");
            fail_count++;
        end

    a_halt_sticky: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
        else begin
            $error("halted dropped without reset");
            fail_count++;
        end

    a_halt_quiet: assert property (@(posedge clk) disable iff (reset) halted |-> !wb_req.stb)
        else begin
            $error("bus request while halted");
            fail_count++;
        end

endmodule

bind rv_core rv_core_props u_props (
    .clk    (clk),
    .reset  (reset),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .halted (halted)
);

`default_nettype wire

// File: dv/rv_core_tb.sv
// Testbench for the multi-cycle RV32I core
// Wishbone memory model, program builders and directed tests
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;
    import rv_pkg::*;

    localparam int  MAX_INSTR  = 400;
    localparam real TIMEOUT_NS = (MAX_INSTR * 10 + 4 * 60) * 20.0;
    localparam int  DATA_BASE  = 'h400;
    localparam int  GUARD_ADDR = 'h7fc;

    logic    clk;
    logic    reset;
    logic    halted;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    word_t   mem [1024];
    word_t   snapshot [256];
    word_t   prog [$];
    int      exp_addr [$];
    word_t   exp_val [$];
    logic [3:0] exp_sel [$];
    word_t   exp_lane [$];
    logic [3:0] log_sel [$];
    word_t   log_dat [$];
    word_t   lfsr_state = 32'hd0953536;
    int      wait_cnt;
    logic    rand_wait;
    int      error_count;

    rv_core DUT (
        .clk    (clk),
        .reset  (reset),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .halted (halted)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the core did not finish the tests in time");
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        wait (DUT.u_props.fail_count != 0);
        $display("A bus protocol or halt assertion failed");
        fail_stop();
    end

    // Galois LFSR stepped once per bit taken
    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
        end
        return v;
    endfunction

    function automatic word_t fill_word(input word_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h5a3c_96e1;
    endfunction

    // Slave answers a fixed 1 ns after the edge with ack after 0 to 3 wait states
    always @(posedge clk) begin
        #1;
        if (reset) begin
            wb_rsp.ack = 1'b0;
            wait_cnt   = 0;
        end else if (wb_rsp.ack) begin
            wb_rsp.ack = 1'b0;
        end else if (wb_req.cyc && wb_req.stb) begin
            if (wait_cnt == 0) begin
                wb_rsp.ack   = 1'b1;
                wb_rsp.dat_r = mem[wb_req.adr[11:2]];
                if (wb_req.we) begin
                    for (int i = 0; i < 4; i++) begin
                        if (wb_req.sel[i]) begin
                            mem[wb_req.adr[11:2]][8*i +: 8] = wb_req.dat_w[8*i +: 8];
                        end
                    end
                    log_sel.push_back(wb_req.sel);
                    log_dat.push_back(wb_req.dat_w);
                end
                wait_cnt = rand_wait ? int'(rand_bits(2)) : 0;
            end else begin
                wait_cnt--;
            end
        end
    end

    task automatic fail_stop();
        $display("RESULT: FAIL");
        $fatal(1, "stopping after the first error");
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            error_count++;
            $display("error at %0t ns: %s got %08h expected %08h", $time, what, got, exp);
            fail_stop();
        end
    endtask

    task automatic check_sel(input logic [3:0] got, input logic [3:0] exp, input string what);
        if (got !== exp) begin
            error_count++;
            $display("error at %0t ns: %s sel %04b expected %04b", $time, what, got, exp);
            fail_stop();
        end
    endtask

    function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd,
                                    input opcode_e op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t enc_b(input logic [12:0] off, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic word_t enc_j(input logic [20:0] off, input reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic word_t alu_model(input logic [2:0] f3, input logic alt, input word_t a,
                                        input word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic int cur_pc();
        return prog.size() * 4;
    endfunction

    task automatic load_li(input reg_addr_t rd, input word_t value);
        word_t hi;
        hi = (value + 32'h800) >> 12;
        prog.push_back({hi[19:0], rd, OPC_LUI});
        prog.push_back(enc_i(value[11:0], rd, 3'd0, rd, OPC_OP_IMM));
    endtask

    // Stores a register to the next result slot and records the expected word
    task automatic store_check(input reg_addr_t rs, input word_t expected);
        int addr;
        addr = DATA_BASE + 4 * exp_addr.size();
        prog.push_back(enc_s(addr[11:0], rs, 5'd0, 3'b010));
        exp_addr.push_back(addr);
        exp_val.push_back(expected);
    endtask

    task automatic start_program();
        prog.delete();
        exp_addr.delete();
        exp_val.delete();
        exp_sel.delete();
        exp_lane.delete();
    endtask

    task automatic run_program();
        int cycles;
        prog.push_back(32'h0010_0073); // EBREAK
        prog.push_back(enc_s(GUARD_ADDR[11:0], 5'd1, 5'd0, 3'b010));
        reset = 1'b1;
        log_sel.delete();
        log_dat.delete();
        for (int i = 0; i < 1024; i++) mem[i] = fill_word(i * 4);
        foreach (prog[i]) mem[i] = prog[i];
        repeat (16) begin
            @(posedge clk);
            #1;
            check_word({29'b0, wb_req.cyc, wb_req.stb, halted}, 32'd0, "bus idle in reset");
        end
        reset = 1'b0;
        cycles = 0;
        while (!wb_req.stb && cycles < 10) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        check_word(wb_req.adr, RESET_PC, "first fetch address");
        check_word({31'b0, wb_req.we}, 32'd0, "first fetch is a read");
        check_sel(wb_req.sel, 4'b1111, "first fetch");
        cycles = 0;
        while (!halted) begin
            if (cycles > MAX_INSTR * 10) begin
                $display("The core never halted");
                fail_stop();
            end
            @(posedge clk);
            #1;
            cycles++;
        end
        repeat (20) begin
            @(posedge clk);
            #1;
            check_word({30'b0, halted, wb_req.stb}, 32'd2, "halted and bus quiet");
        end
        check_word(mem[GUARD_ADDR / 4], fill_word(GUARD_ADDR), "store after EBREAK");
        foreach (exp_addr[i]) check_word(mem[exp_addr[i] / 4], exp_val[i], "result word");
    endtask

    task automatic build_alu();
        word_t a;
        word_t b;
        word_t imm;
        word_t u;
        int    p;
        start_program();
        a = rand_bits(32);
        b = rand_bits(32);
        load_li(5'd1, a);
        load_li(5'd2, b);
        for (int f3 = 0; f3 < 8; f3++) begin
            prog.push_back(enc_r(7'h00, 5'd2, 5'd1, f3[2:0], 5'd3));
            store_check(5'd3, alu_model(f3[2:0], 1'b0, a, b));
        end
        prog.push_back(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd3)); // SUB
        store_check(5'd3, alu_model(3'd0, 1'b1, a, b));
        prog.push_back(enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd3)); // SRA
        store_check(5'd3, alu_model(3'd5, 1'b1, a, b));
        for (int f3 = 0; f3 < 8; f3++) begin
            imm = rand_bits(12);
            if (f3 == 1 || f3 == 5) imm = {27'b0, imm[4:0]};
            imm = {{20{imm[11]}}, imm[11:0]};
            prog.push_back(enc_i(imm[11:0], 5'd1, f3[2:0], 5'd3, OPC_OP_IMM));
            store_check(5'd3, alu_model(f3[2:0], 1'b0, a, imm));
        end
        prog.push_back(enc_i({7'h20, imm[4:0]}, 5'd1, 3'd5, 5'd3, OPC_OP_IMM)); // SRAI
        store_check(5'd3, alu_model(3'd5, 1'b1, a, {27'b0, imm[4:0]}));
        u = rand_bits(20);
        prog.push_back({u[19:0], 5'd3, OPC_LUI});
        store_check(5'd3, {u[19:0], 12'b0});
        p = cur_pc();
        prog.push_back({u[19:0], 5'd3, OPC_AUIPC});
        store_check(5'd3, word_t'(p) + {u[19:0], 12'b0});
    endtask

    task automatic test_alu_and_backpressure();
        word_t saved [$];
        build_alu();
        saved = prog;
        rand_wait = 1'b0;
        run_program();
        for (int i = 0; i < 256; i++) snapshot[i] = mem[256 + i];
        prog = saved;
        rand_wait = 1'b1;
        run_program();
        for (int i = 0; i < 256; i++) begin
            check_word(mem[256 + i], snapshot[i], "rerun with wait states");
        end
    endtask

    task automatic test_load_store();
        word_t v;
        word_t w;
        word_t old;
        int    a;
        start_program();
        v = rand_bits(32);
        w = rand_bits(32);
        load_li(5'd1, v);
        load_li(5'd2, w);
        for (int k = 0; k < 4; k++) begin
            a = 'h500 + 4 * k + k;
            prog.push_back(enc_s(a[11:0], 5'd1, 5'd0, 3'b000));
            exp_sel.push_back(4'b0001 << k);
            exp_lane.push_back({24'b0, v[7:0]} << (8 * k));
        end
        prog.push_back(enc_s(12'h520, 5'd1, 5'd0, 3'b001));
        exp_sel.push_back(4'b0011);
        exp_lane.push_back({16'b0, v[15:0]});
        prog.push_back(enc_s(12'h526, 5'd1, 5'd0, 3'b001));
        exp_sel.push_back(4'b1100);
        exp_lane.push_back({v[15:0], 16'b0});
        prog.push_back(enc_s(12'h530, 5'd2, 5'd0, 3'b010));
        exp_sel.push_back(4'b1111);
        exp_lane.push_back(w);
        prog.push_back(enc_i(12'h531, 5'd0, 3'b000, 5'd3, OPC_LOAD)); // LB
        store_check(5'd3, {{24{w[15]}}, w[15:8]});
        prog.push_back(enc_i(12'h533, 5'd0, 3'b100, 5'd3, OPC_LOAD)); // LBU
        store_check(5'd3, {24'b0, w[31:24]});
        prog.push_back(enc_i(12'h532, 5'd0, 3'b001, 5'd3, OPC_LOAD)); // LH
        store_check(5'd3, {{16{w[31]}}, w[31:16]});
        prog.push_back(enc_i(12'h530, 5'd0, 3'b101, 5'd3, OPC_LOAD)); // LHU
        store_check(5'd3, {16'b0, w[15:0]});
        prog.push_back(enc_i(12'h530, 5'd0, 3'b010, 5'd3, OPC_LOAD)); // LW
        store_check(5'd3, w);
        rand_wait = 1'b1;
        run_program();
        foreach (exp_sel[i]) begin
            check_sel(log_sel[i], exp_sel[i], "store byte lanes");
            for (int l = 0; l < 4; l++) begin
                if (exp_sel[i][l]) begin
                    check_word(log_dat[i][8*l +: 8], exp_lane[i][8*l +: 8], "lane data");
                end
            end
        end
        for (int k = 0; k < 4; k++) begin
            old = fill_word('h500 + 4 * k);
            old[8*k +: 8] = v[7:0];
            check_word(mem[('h500 + 4 * k) / 4], old, "byte store word");
        end
        old = fill_word('h520);
        check_word(mem['h520 / 4], {old[31:16], v[15:0]}, "low halfword store");
        old = fill_word('h524);
        check_word(mem['h524 / 4], {v[15:0], old[15:0]}, "high halfword store");
    endtask

    task automatic test_control_flow();
        word_t      rv [4];
        logic [2:0] f3s [12] = '{0, 0, 1, 1, 4, 4, 5, 5, 6, 6, 7, 7};
        reg_addr_t  r1s [12] = '{1, 1, 1, 1, 2, 1, 1, 2, 1, 2, 2, 1};
        reg_addr_t  r2s [12] = '{3, 2, 2, 3, 1, 2, 2, 1, 2, 1, 1, 2};
        int         p;
        start_program();
        rv = '{32'd0, 32'd5, 32'hffff_fffd, 32'd5};
        for (int r = 1; r < 4; r++) load_li(r[4:0], rv[r]);
        for (int k = 0; k < 12; k++) begin
            prog.push_back(enc_b(13'd12, r2s[k], r1s[k], f3s[k]));
            prog.push_back(enc_i(12'h200 + k, 5'd0, 3'd0, 5'd10, OPC_OP_IMM));
            prog.push_back(enc_j(21'd8, 5'd0));
            prog.push_back(enc_i(12'h100 + k, 5'd0, 3'd0, 5'd10, OPC_OP_IMM));
            store_check(5'd10, branch_model(f3s[k], rv[r1s[k]], rv[r2s[k]]) ? 32'h100 + k
                                                                           : 32'h200 + k);
        end
        p = cur_pc();
        prog.push_back(enc_j(21'd8, 5'd5));
        prog.push_back(enc_i(12'h3ff, 5'd0, 3'd0, 5'd11, OPC_OP_IMM));
        store_check(5'd5, p + 4);
        store_check(5'd11, 32'd0);
        p = cur_pc();
        prog.push_back({20'd0, 5'd6, OPC_AUIPC});
        prog.push_back(enc_i(12'd13, 5'd6, 3'd0, 5'd7, OPC_JALR)); // target has bit 0 set
        prog.push_back(enc_i(12'h3ff, 5'd0, 3'd0, 5'd11, OPC_OP_IMM));
        store_check(5'd7, p + 8);
        store_check(5'd11, 32'd0);
        rand_wait = 1'b1;
        run_program();
    endtask

    initial begin
        reset       = 1'b1;
        wb_rsp      = '0;
        rand_wait   = 1'b0;
        wait_cnt    = 0;
        error_count = 0;
        test_alu_and_backpressure();
        test_load_store();
        test_control_flow();
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
verilog/rv_pkg.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_execute.sv
verilog/rv_lsu.sv
verilog/rv_core.sv
dv/rv_core_props.sv
dv/rv_core_tb.sv

// File: verilog/rv_core.sv
// Multi-cycle RV32I core
// Fetch, execute and memory states sharing one Wishbone classic master port
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  logic            clk,
    input  logic            reset,
    output rv_pkg::wb_req_t wb_req,
    input  rv_pkg::wb_rsp_t wb_rsp,
    output logic            halted
);
    import rv_pkg::*;

    core_state_e  state;
    logic         bus_active;
    word_t        pc;
    word_t        ir;
    word_t        next_pc;
    decoded_t     dec;
    word_t        rs1_data;
    word_t        rs2_data;
    exec_result_t res;
    logic [3:0]   lsu_sel;
    word_t        lsu_wdata;
    word_t        load_data;
    logic         mem_op;
    logic         bus_done;
    logic         rf_we;
    word_t        rf_wdata;

    rv_decoder u_decoder (
        .inst (ir),
        .dec  (dec)
    );

    rv_regfile u_regfile (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data),
        .we     (rf_we),
        .waddr  (dec.rd),
        .wdata  (rf_wdata)
    );

    rv_execute u_execute (
        .dec      (dec),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .res      (res)
    );

    rv_lsu u_lsu (
        .dec        (dec),
        .addr       (res.result),
        .store_data (rs2_data),
        .bus_rdata  (wb_rsp.dat_r),
        .sel        (lsu_sel),
        .bus_wdata  (lsu_wdata),
        .load_data  (load_data)
    );

    assign mem_op   = dec.is_load || dec.is_store;
    assign bus_done = bus_active && wb_rsp.ack;
    assign next_pc  = res.jump_en ? res.jump_target : pc + 32'd4;

    // Writeback at the end of EXECUTE, or on the ack of a load
    assign rf_we    = dec.writes_rd && ((state == EXECUTE && !mem_op) ||
                                        (state == MEMORY && bus_done && dec.is_load));
    assign rf_wdata = (state == MEMORY) ? load_data : res.result;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= FETCH;
            bus_active <= 1'b0;
            pc         <= RESET_PC;
        end else begin
            unique case (state)
                FETCH: begin
                    if (!bus_active) begin
                        bus_active <= 1'b1;
                    end else if (wb_rsp.ack) begin
                        bus_active <= 1'b0;
                        state      <= EXECUTE;
                    end
                end
                EXECUTE: begin
                    if (dec.is_ebreak) begin
                        state <= HALT;
                    end else if (mem_op) begin
                        bus_active <= 1'b1;
                        state      <= MEMORY;
                    end else begin
                        pc         <= next_pc;
                        bus_active <= 1'b1; // next fetch starts right away
                        state      <= FETCH;
                    end
                end
                MEMORY: begin
                    if (wb_rsp.ack) begin
                        pc         <= next_pc;
                        bus_active <= 1'b0;
                        state      <= FETCH;
                    end
                end
                default: ; // HALT until reset
            endcase
        end
    end

    // Instruction register, loaded on the fetch ack
    always_ff @(posedge clk) begin
        if (state == FETCH && bus_done) begin
            ir <= wb_rsp.dat_r;
        end
    end

    always_comb begin
        wb_req.cyc   = bus_active;
        wb_req.stb   = bus_active;
        wb_req.we    = bus_active && state == MEMORY && dec.is_store;
        wb_req.adr   = (state == MEMORY) ? res.result : pc;
        wb_req.sel   = (state == MEMORY) ? lsu_sel : 4'b1111;
        wb_req.dat_w = lsu_wdata;
    end

    assign halted = (state == HALT);

endmodule

`default_nettype wire

// File: verilog/rv_decoder.sv
// Instruction decoder
// Extracts fields, builds the immediate and derives control flags
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
    input  rv_pkg::word_t    inst,
    output rv_pkg::decoded_t dec
);
    import rv_pkg::*;

    opcode_e    opcode;
    fmt_e       fmt;
    logic [6:0] funct7;
    logic [2:0] funct3;
    reg_addr_t  rd;
    word_t      imm;

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];

    always_comb begin
        unique case (opcode)
            OPC_OP_IMM, OPC_LOAD, OPC_JALR, OPC_SYSTEM: fmt = FMT_I;
            OPC_STORE:                                  fmt = FMT_S;
            OPC_BRANCH:                                 fmt = FMT_B;
            OPC_LUI, OPC_AUIPC:                         fmt = FMT_U;
            OPC_JAL:                                    fmt = FMT_J;
            default:                                    fmt = FMT_R; // OP and unknown
        endcase
    end

    always_comb begin
        unique case (fmt)
            FMT_I:   imm = {{20{inst[31]}}, inst[31:20]};
            FMT_S:   imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            FMT_B:   imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            FMT_U:   imm = {inst[31:12], 12'b0};
            FMT_J:   imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    always_comb begin
        dec        = '0;
        dec.rd     = rd;
        dec.rs1    = inst[19:15];
        dec.rs2    = inst[24:20];
        dec.imm    = imm;
        dec.funct3 = funct3;
        dec.alu_op = ALU_ADD;

        if (opcode == OPC_OP || opcode == OPC_OP_IMM) begin
            unique case (funct3)
                3'b000: begin
                    // Only the register form has SUB
                    if (opcode == OPC_OP && funct7[5]) begin
                        dec.alu_op = ALU_SUB;
                    end
                end
                3'b001:  dec.alu_op = ALU_SLL;
                3'b010:  dec.alu_op = ALU_SLT;
                3'b011:  dec.alu_op = ALU_SLTU;
                3'b100:  dec.alu_op = ALU_XOR;
                3'b101:  dec.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                3'b110:  dec.alu_op = ALU_OR;
                default: dec.alu_op = ALU_AND;
            endcase
        end

        dec.is_load   = (opcode == OPC_LOAD);
        dec.is_store  = (opcode == OPC_STORE);
        dec.is_branch = (opcode == OPC_BRANCH);
        dec.is_jal    = (opcode == OPC_JAL);
        dec.is_jalr   = (opcode == OPC_JALR);
        dec.is_lui    = (opcode == OPC_LUI);
        dec.is_auipc  = (opcode == OPC_AUIPC);
        dec.use_imm   = (fmt != FMT_R) && (fmt != FMT_B);
        dec.is_ebreak = (opcode == OPC_SYSTEM) && (funct3 == 3'b000)
                        && (inst[31:20] == 12'h001);

        // Stores, branches, SYSTEM and unknown opcodes never write rd
        dec.writes_rd = (rd != 5'd0) &&
                        (opcode == OPC_OP || opcode == OPC_OP_IMM || opcode == OPC_LOAD ||
                         opcode == OPC_LUI || opcode == OPC_AUIPC ||
                         opcode == OPC_JAL || opcode == OPC_JALR);
    end

endmodule

`default_nettype wire

// File: verilog/rv_execute.sv
// Execute unit
// ALU, branch compare and jump target generation
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  rv_pkg::decoded_t     dec,
    input  rv_pkg::word_t        pc,
    input  rv_pkg::word_t        rs1_data,
    input  rv_pkg::word_t        rs2_data,
    output rv_pkg::exec_result_t res
);
    import rv_pkg::*;

    word_t      op_a;
    word_t      op_b;
    word_t      alu_out;
    word_t      pc_plus4;
    logic [4:0] shamt;
    logic       take;

    // LUI adds to zero, AUIPC to the PC
    always_comb begin
        if (dec.is_lui) begin
            op_a = '0;
        end else if (dec.is_auipc) begin
            op_a = pc;
        end else begin
            op_a = rs1_data;
        end
    end

    assign op_b     = dec.use_imm ? dec.imm : rs2_data;
    assign shamt    = op_b[4:0];
    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        unique case (dec.alu_op)
            ALU_SUB:  alu_out = op_a - op_b;
            ALU_SLL:  alu_out = op_a << shamt;
            ALU_SLT:  alu_out = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
            ALU_SLTU: alu_out = (op_a < op_b) ? 32'd1 : 32'd0;
            ALU_XOR:  alu_out = op_a ^ op_b;
            ALU_SRL:  alu_out = op_a >> shamt;
            ALU_SRA:  alu_out = word_t'($signed(op_a) >>> shamt);
            ALU_OR:   alu_out = op_a | op_b;
            ALU_AND:  alu_out = op_a & op_b;
            default:  alu_out = op_a + op_b;
        endcase
    end

    always_comb begin
        unique case (dec.funct3)
            3'b000:  take = (rs1_data == rs2_data);
            3'b001:  take = (rs1_data != rs2_data);
            3'b100:  take = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  take = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  take = (rs1_data < rs2_data);
            3'b111:  take = (rs1_data >= rs2_data);
            default: take = 1'b0;
        endcase
    end

    always_comb begin
        res.jump_en = dec.is_jal || dec.is_jalr || (dec.is_branch && take);

        if (dec.is_jalr) begin
            res.jump_target = {alu_out[31:1], 1'b0}; // rs1 + imm with bit 0 cleared
        end else begin
            res.jump_target = pc + dec.imm;
        end

        // Link value for JAL/JALR
        res.result = (dec.is_jal || dec.is_jalr) ? pc_plus4 : alu_out;
    end

endmodule

`default_nettype wire

// File: verilog/rv_lsu.sv
// Load/store unit
// Byte lane selects, store data alignment and load extraction
`timescale 1ns/1ps
`default_nettype none

module rv_lsu (
    input  rv_pkg::decoded_t dec,
    input  rv_pkg::word_t    addr,
    input  rv_pkg::word_t    store_data,
    input  rv_pkg::word_t    bus_rdata,
    output logic [3:0]       sel,
    output rv_pkg::word_t    bus_wdata,
    output rv_pkg::word_t    load_data
);
    import rv_pkg::*;

    logic [1:0] lane;
    logic [3:0] mask;
    word_t      rdata_shifted;

    // funct3[1:0] gives the access size
    always_comb begin
        unique case (dec.funct3[1:0])
            2'b00: begin
                lane = addr[1:0];
                mask = 4'b0001;
            end
            2'b01: begin
                lane = {addr[1], 1'b0};
                mask = 4'b0011;
            end
            default: begin
                lane = 2'b00;
                mask = 4'b1111;
            end
        endcase
    end

    assign sel           = mask << lane;
    assign bus_wdata     = store_data << {lane, 3'b000};
    assign rdata_shifted = bus_rdata >> {lane, 3'b000};

    always_comb begin
        unique case (dec.funct3)
            3'b000:  load_data = {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};   // LB
            3'b001:  load_data = {{16{rdata_shifted[15]}}, rdata_shifted[15:0]}; // LH
            3'b100:  load_data = {24'b0, rdata_shifted[7:0]};                    // LBU
            3'b101:  load_data = {16'b0, rdata_shifted[15:0]};                   // LHU
            default: load_data = rdata_shifted;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/rv_pkg.sv
// Shared types for the RV32I core
// Widths, opcode/ALU/format/state encodings and the bus and decode structs
`default_nettype none

package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    localparam word_t RESET_PC = 32'h0000_0000;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // Immediate formats
    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J
    } fmt_e;

    typedef enum logic [1:0] {
        FETCH,
        EXECUTE,
        MEMORY,
        HALT
    } core_state_e;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        word_t      adr;
        word_t      dat_w;
        logic [3:0] sel;
    } wb_req_t;

    typedef struct packed {
        word_t dat_r;
        logic  ack;
    } wb_rsp_t;

    typedef struct packed {
        alu_op_e    alu_op;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        word_t      imm;
        logic [2:0] funct3;
        logic       is_load;
        logic       is_store;
        logic       is_branch;
        logic       is_jal;
        logic       is_jalr;
        logic       is_lui;
        logic       is_auipc;
        logic       use_imm;
        logic       writes_rd;
        logic       is_ebreak;
    } decoded_t;

    typedef struct packed {
        word_t result;
        logic  jump_en;
        word_t jump_target;
    } exec_result_t;

endpackage

`default_nettype wire

// File: verilog/rv_regfile.sv
// Integer register file, 32 x 32 bits
// Two combinational read ports, one write port, x0 reads as zero
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  logic              clk,
    input  logic              reset,
    input  rv_pkg::reg_addr_t raddr1,
    input  rv_pkg::reg_addr_t raddr2,
    output rv_pkg::word_t     rdata1,
    output rv_pkg::word_t     rdata2,
    input  logic              we,
    input  rv_pkg::reg_addr_t waddr,
    input  rv_pkg::word_t     wdata
);
    import rv_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire
